// File: logic/lcd_pkg.sv
package lcd_pkg;

    // one word on the HD44780 bus
    typedef struct packed {
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    typedef enum logic [2:0] {
        power_wait   = 3'b000,
        function_set = 3'b001,
        entry_mode   = 3'b010,
        display_on   = 3'b011,
        line1        = 3'b100,
        line2        = 3'b101,
        return_home  = 3'b110,
        clear_disp   = 3'b111
    } lcd_phase_e;

    typedef logic [8:0] step_t;  // covers the 400 cycle home phase

    localparam logic [7:0] cmd_function_set = 8'h38;  // 8 bit, 2 lines, 5x8
    localparam logic [7:0] cmd_entry_mode   = 8'h06;  // increment, no shift
    localparam logic [7:0] cmd_display_on   = 8'h0C;  // cursor off
    localparam logic [7:0] cmd_return_home  = 8'h02;
    localparam logic [7:0] cmd_clear        = 8'h01;
    localparam logic [7:0] addr_line1       = 8'h80;
    localparam logic [7:0] addr_line2       = 8'hC0;

    localparam lcd_bus_t bus_idle = '{rs: 1'b1, rw: 1'b1, data: 8'h00};

    function automatic lcd_bus_t cmd_word(logic [7:0] value);
        return '{rs: 1'b0, rw: 1'b0, data: value};
    endfunction

    function automatic lcd_bus_t data_word(logic [7:0] value);
        return '{rs: 1'b1, rw: 1'b0, data: value};
    endfunction

endpackage

// File: logic/game_text_pkg.sv
package game_text_pkg;

    // prompt selector from the game FSM
    typedef enum logic [2:0] {
        msg_correct = 3'b000,
        msg_up      = 3'b010,
        msg_down    = 3'b011,
        msg_failed  = 3'b100,
        msg_start   = 3'b101,
        msg_enter   = 3'b110
    } msg_op_e;

    localparam logic [7:0] char_space      = 8'h20;
    localparam logic [7:0] char_digit_zero = 8'h30;

    // character slots after the address byte
    localparam int unsigned line_chars = 16;

    // leftmost character sits in the top byte
    typedef logic [8*line_chars-1:0] line_text_t;

    localparam line_text_t text_blank = {line_chars{char_space}};

    // slot 1 is the first character, anything outside the line is blank
    function automatic logic [7:0] text_char(line_text_t text, int unsigned slot);
        if (slot == 0 || slot > line_chars) begin
            return char_space;
        end
        return text[8*(line_chars - slot) +: 8];
    endfunction

    function automatic logic [7:0] digit_char(int unsigned value);
        return char_digit_zero + 8'(value);
    endfunction

    // slot holding the trials-left digit on line 2
    localparam int unsigned digit_slot = 12;

    // largest count shown as itself
    localparam int unsigned max_shown_trials = 5;

endpackage

// File: logic/lcd_init_sequencer.sv
`timescale 1ns/1ps

module lcd_init_sequencer #(
    parameter int unsigned powerup_cycles = 70,
    parameter int unsigned config_cycles  = 30,
    parameter int unsigned line_cycles    = 20,
    parameter int unsigned home_cycles    = 400,
    parameter int unsigned clear_cycles   = 200
) (
    input  logic                clk,
    input  logic                resetn,
    output lcd_pkg::lcd_phase_e phase,
    output lcd_pkg::step_t      step
);
    import lcd_pkg::*;

    step_t      limit;
    lcd_phase_e next_phase;

    // last step of the current phase
    always_comb begin
        case (phase)
            power_wait: begin
                limit = step_t'(powerup_cycles);
            end
            function_set, entry_mode, display_on: begin
                limit = step_t'(config_cycles);
            end
            line1, line2: begin
                limit = step_t'(line_cycles);
            end
            return_home: begin
                limit = step_t'(home_cycles);
            end
            clear_disp: begin
                limit = step_t'(clear_cycles);
            end
            default: begin
                limit = step_t'(powerup_cycles);
            end
        endcase
    end

    always_comb begin
        case (phase)
            power_wait: begin
                next_phase = function_set;
            end
            function_set: begin
                next_phase = entry_mode;
            end
            entry_mode: begin
                next_phase = display_on;
            end
            display_on: begin
                next_phase = line1;
            end
            line1: begin
                next_phase = line2;
            end
            line2: begin
                next_phase = return_home;
            end
            return_home: begin
                next_phase = clear_disp;
            end
            default: begin
                next_phase = line1;  // clear_disp starts the next frame
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase <= power_wait;
            step  <= '0;
        end else if (step == limit) begin
            phase <= next_phase;
            step  <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

// File: logic/prompt_text.sv
`timescale 1ns/1ps

module prompt_text (
    input  lcd_pkg::step_t         step,
    input  game_text_pkg::msg_op_e op,
    output lcd_pkg::lcd_bus_t      prompt_word
);
    import lcd_pkg::*;
    import game_text_pkg::*;

    // sixteen characters each, padded with blanks
    localparam line_text_t text_correct = "Correct!        ";
    localparam line_text_t text_failed  = "game failed!    ";
    localparam line_text_t text_up      = "UP              ";
    localparam line_text_t text_down    = "DOWN            ";
    localparam line_text_t text_start   = "game start!     ";
    localparam line_text_t text_enter   = "enter any number";

    line_text_t text;

    always_comb begin
        case (op)
            msg_correct: begin
                text = text_correct;
            end
            msg_failed: begin
                text = text_failed;
            end
            msg_up: begin
                text = text_up;
            end
            msg_down: begin
                text = text_down;
            end
            msg_start: begin
                text = text_start;
            end
            msg_enter: begin
                text = text_enter;
            end
            default: begin
                text = text_blank;  // 001 and 111
            end
        endcase
    end

    // address first, then one character per step
    always_comb begin
        if (step == '0) begin
            prompt_word = cmd_word(addr_line1);
        end else begin
            prompt_word = data_word(text_char(text, int'(step)));
        end
    end

endmodule

// File: logic/status_text.sv
`timescale 1ns/1ps

module status_text #(
    parameter int unsigned trial_width = 32
) (
    input  lcd_pkg::step_t         step,
    input  game_text_pkg::msg_op_e op,
    input  logic [trial_width-1:0] trial_left,
    output lcd_pkg::lcd_bus_t      status_word
);
    import lcd_pkg::*;
    import game_text_pkg::*;

    localparam line_text_t text_retry = "retry?          ";
    localparam line_text_t text_trial = "trial left      ";

    logic       show_retry;
    logic       count_shown;
    logic [7:0] digit;
    line_text_t text;

    // game over either way
    assign show_retry = (op == msg_correct) || (op == msg_failed);

    assign count_shown = (trial_left != '0) &&
                         (trial_left <= trial_width'(max_shown_trials));

    always_comb begin
        if (count_shown) begin
            digit = char_digit_zero + 8'(trial_left);
        end else begin
            digit = digit_char(max_shown_trials + 1);  // out of range shows 6
        end
    end

    assign text = show_retry ? text_retry : text_trial;

    always_comb begin
        if (step == '0) begin
            status_word = cmd_word(addr_line2);
        end else if (!show_retry && int'(step) == digit_slot) begin
            status_word = data_word(digit);
        end else begin
            status_word = data_word(text_char(text, int'(step)));
        end
    end

endmodule

// File: logic/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver (
    input  logic                clk,
    input  logic                resetn,
    input  lcd_pkg::lcd_phase_e phase,
    input  lcd_pkg::lcd_bus_t   prompt_word,
    input  lcd_pkg::lcd_bus_t   status_word,
    output lcd_pkg::lcd_bus_t   lcd
);
    import lcd_pkg::*;

    lcd_bus_t next_word;

    always_comb begin
        case (phase)
            function_set: begin
                next_word = cmd_word(cmd_function_set);
            end
            entry_mode: begin
                next_word = cmd_word(cmd_entry_mode);
            end
            display_on: begin
                next_word = cmd_word(cmd_display_on);
            end
            line1: begin
                next_word = prompt_word;
            end
            line2: begin
                next_word = status_word;
            end
            return_home: begin
                next_word = cmd_word(cmd_return_home);
            end
            clear_disp: begin
                next_word = cmd_word(cmd_clear);
            end
            default: begin
                next_word = bus_idle;  // power-up wait
            end
        endcase
    end

    // bus lags phase and step by one clock
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lcd <= bus_idle;
        end else begin
            lcd <= next_word;
        end
    end

endmodule

// File: logic/textlcd.sv
`timescale 1ns/1ps

module textlcd #(
    parameter int unsigned powerup_cycles = 70,
    parameter int unsigned config_cycles  = 30,
    parameter int unsigned line_cycles    = 20,
    parameter int unsigned home_cycles    = 400,
    parameter int unsigned clear_cycles   = 200,
    parameter int unsigned trial_width    = 32
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  game_text_pkg::msg_op_e output_command,
    input  logic [trial_width-1:0] trial_left,
    output logic                   lcd_e,
    output lcd_pkg::lcd_bus_t      lcd
);
    import lcd_pkg::*;

    lcd_phase_e phase;
    step_t      step;
    lcd_bus_t   prompt_word;
    lcd_bus_t   status_word;

    lcd_init_sequencer #(
        .powerup_cycles (powerup_cycles),
        .config_cycles  (config_cycles),
        .line_cycles    (line_cycles),
        .home_cycles    (home_cycles),
        .clear_cycles   (clear_cycles)
    ) i_sequencer (
        .clk    (clk),
        .resetn (resetn),
        .phase  (phase),
        .step   (step)
    );

    prompt_text i_prompt (
        .step        (step),
        .op          (output_command),
        .prompt_word (prompt_word)
    );

    status_text #(
        .trial_width (trial_width)
    ) i_status (
        .step        (step),
        .op          (output_command),
        .trial_left  (trial_left),
        .status_word (status_word)
    );

    lcd_bus_driver i_driver (
        .clk         (clk),
        .resetn      (resetn),
        .phase       (phase),
        .prompt_word (prompt_word),
        .status_word (status_word),
        .lcd         (lcd)
    );

    assign lcd_e = clk;  // enable follows the clock

endmodule

// File: include/tb_screen_text.svh
`ifndef TB_SCREEN_TEXT_SVH
`define TB_SCREEN_TEXT_SVH

// data bytes captured after each address byte
localparam int tb_capture_len = 20;

function automatic string line1_text(logic [2:0] op);
    case (op)
        3'b000:  return "Correct!";
        3'b100:  return "game failed!";
        3'b010:  return "UP";
        3'b011:  return "DOWN";
        3'b101:  return "game start!";
        3'b110:  return "enter any number";
        default: return "";  // blank line
    endcase
endfunction

// counts 1 to 5 as themselves, everything else as 6
function automatic byte trial_digit(logic [31:0] trial_left);
    if (trial_left >= 1 && trial_left <= 5) begin
        return byte'("0") + byte'(trial_left);
    end
    return byte'("6");
endfunction

function automatic string line2_text(logic [2:0] op, logic [31:0] trial_left);
    if (op == 3'b000 || op == 3'b100) begin
        return "retry?";
    end
    return $sformatf("trial left %c", trial_digit(trial_left));
endfunction

// slot 0 is the first byte after the address
function automatic byte slot_char(string text, int slot);
    if (slot < text.len()) begin
        return text[slot];
    end
    return byte'(" ");
endfunction

`endif

// File: bench/textlcd_tb.sv
`timescale 1ns/1ps

module textlcd_tb;
    import lcd_pkg::*;
    import game_text_pkg::*;

    `include "tb_screen_text.svh"

    localparam int powerup_c = 70;
    localparam int config_c  = 30;
    localparam int line_c    = 20;
    localparam int home_c    = 40;  // shortened
    localparam int clear_c   = 20;  // shortened
    localparam int n_frames  = 11;
    localparam int frame_len = 2 * (line_c + 1) + home_c + 1 + clear_c + 1;
    localparam int init_len  = 16 + powerup_c + 2 + 3 * (config_c + 1);
    localparam int run_limit = (init_len + n_frames * frame_len) * 6 / 5;

    logic        clk;
    logic        resetn;
    msg_op_e     output_command;
    logic [31:0] trial_left;
    logic        lcd_e;
    lcd_bus_t    lcd;

    int          seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          cycle_count;
    int          len;
    logic [2:0]  test_op [n_frames];
    logic [31:0] test_tl [n_frames];
    lcd_bus_t    line_buf [tb_capture_len];

    textlcd #(
        .home_cycles  (home_c),
        .clear_cycles (clear_c)
    ) i_dut (
        .clk            (clk),
        .resetn         (resetn),
        .output_command (output_command),
        .trial_left     (trial_left),
        .lcd_e          (lcd_e),
        .lcd            (lcd)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic lcd_bus_t bus_word(logic rs_bit, logic rw_bit, logic [7:0] value);
        return '{rs: rs_bit, rw: rw_bit, data: value};
    endfunction

    // sample and drive just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(string name, lcd_bus_t got, lcd_bus_t exp);
        assert (got === exp) else begin
            $display("error at %0d ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp, int tol);
        assert (got >= exp - tol && got <= exp + tol) else begin
            $display("error at %0d ns: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_enable(logic exp);
        assert (lcd_e === exp) else begin
            $display("error at %0d ns: lcd_e expected %b got %b", $time, exp, lcd_e);
            errors++;
        end
    endtask

    // enable is high in the high half of the clock and low in the low half
    always @(posedge clk) begin
        #1;
        check_enable(1'b1);
    end

    always @(negedge clk) begin
        #1;
        check_enable(1'b0);
    end

    // length of the run that starts at the current sample
    task automatic count_run(lcd_bus_t word, output int run_len);
        run_len = 0;
        while (lcd === word) begin
            run_len++;
            next_cycle();
        end
    endtask

    task automatic capture_line(string name, logic [7:0] addr, string text);
        byte c;
        check_word({name, " address"}, lcd, bus_word(1'b0, 1'b0, addr));
        for (int i = 0; i < tb_capture_len; i++) begin
            next_cycle();
            line_buf[i] = lcd;
        end
        for (int i = 0; i < tb_capture_len; i++) begin
            c = slot_char(text, i);
            check_word($sformatf("%s slot %0d", name, i + 1), line_buf[i],
                       bus_word(1'b1, 1'b0, 8'(c)));
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic run_frame(int idx);
        logic [2:0] op;
        logic [31:0] tl;
        op = test_op[idx];
        tl = test_tl[idx];
        capture_line("lcd line1", 8'h80, line1_text(op));
        next_cycle();
        capture_line("lcd line2", 8'hC0, line2_text(op, tl));
        next_cycle();
        check_word("lcd return home", lcd, bus_word(1'b0, 1'b0, 8'h02));
        if (idx + 1 < n_frames) begin
            output_command = msg_op_e'(test_op[idx + 1]);  // shows up next frame
            trial_left = test_tl[idx + 1];
        end
        count_run(bus_word(1'b0, 1'b0, 8'h02), len);
        check_count("return home run length", len, home_c + 1, 0);
        count_run(bus_word(1'b0, 1'b0, 8'h01), len);
        check_count("clear run length", len, clear_c + 1, 0);
        check_word("lcd after clear", lcd, bus_word(1'b0, 1'b0, 8'h80));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= run_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed = 32'hf5ce179a;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_at_start = 0;
        cycle_count = 0;
        test_op = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b101, 3'b110,
                    3'b010, 3'b011, 3'b110, 3'b001, 3'b111};
        test_tl = '{32'd3, 32'd1, 32'd2, 32'd4, 32'd3, 32'd4,
                    32'd5, 32'd0, 32'd0, 32'd2, 32'd0};
        test_tl[8] = $random(seed) | 32'h8;  // always above 5
        test_tl[10] = $random(seed) | 32'h8;
        resetn = 1'b0;
        output_command = msg_op_e'(test_op[0]);
        trial_left = test_tl[0];

        start_test();
        repeat (16) begin
            next_cycle();
            check_word("lcd in reset", lcd, bus_word(1'b1, 1'b1, 8'h00));
        end
        resetn = 1'b1;
        next_cycle();
        count_run(bus_word(1'b1, 1'b1, 8'h00), len);
        check_count("power-up idle cycles", len, powerup_c + 1, 1);
        finish_test("reset and power-up");

        start_test();
        count_run(bus_word(1'b0, 1'b0, 8'h38), len);
        check_count("function set run length", len, config_c + 1, 0);
        count_run(bus_word(1'b0, 1'b0, 8'h06), len);
        check_count("entry mode run length", len, config_c + 1, 0);
        count_run(bus_word(1'b0, 1'b0, 8'h0C), len);
        check_count("display on run length", len, config_c + 1, 0);
        finish_test("init sequence");

        for (int i = 0; i < n_frames; i++) begin
            start_test();
            run_frame(i);
            finish_test($sformatf("frame %0d op %b trial_left %0d", i, test_op[i], test_tl[i]));
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: textlcd.f
+incdir+include
logic/lcd_pkg.sv
logic/game_text_pkg.sv
logic/lcd_init_sequencer.sv
logic/prompt_text.sv
logic/status_text.sv
logic/lcd_bus_driver.sv
logic/textlcd.sv
bench/textlcd_tb.sv

// File: Makefile
TOP := textlcd_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f textlcd.f --top-module $(TOP)

sim:
	verilator --binary --timing -f textlcd.f --top-module $(TOP) -o textlcd_sim
	./obj_dir/textlcd_sim > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
